/* sim.f */
mem_test_pkg.sv
seg7_decoder.sv
pattern_table.sv
test_counters.sv
result_display.sv
phase_sequencer.sv
mem_test_top.sv
mem_model.sv
mem_test_checker.sv
mem_test_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module mem_test_tb -f sim.f -o mem_test_sim &&
{ ./obj_dir/mem_test_sim +verilator+error+limit+1000 > sim.log 2>&1 || true; } &&
cat sim.log &&
! grep -q "TEST FAIL" sim.log &&
grep -q "TEST PASS" sim.log ||
{ echo "Simulation failed"; exit 1; }

/* mem_test_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_test_tb;

  logic clock = 1'b0;
  logic reset_n = 1'b0;
  logic [9:0] sw = '0;
  logic corrupt = 1'b0;
  logic stuck_ready = 1'b0;
  logic silent = 1'b0;

  mem_test_pkg::mem_addr_t mem_addr;
  mem_test_pkg::mem_data_t mem_wdata;
  mem_test_pkg::mem_data_t mem_rdata;
  logic mem_we;
  logic mem_re;
  logic mem_rvalid;
  logic mem_ready;
  logic done;
  logic phase0_start;
  logic phase1_start;
  logic [1:0] led;
  mem_test_pkg::segments_t hex0;
  mem_test_pkg::segments_t hex1;
  mem_test_pkg::segments_t hex2;
  mem_test_pkg::segments_t hex3;

  int errors = 0;
  int checks = 0;

  int phase; // 0 before phase0_start, 1 in phase 0, 2 in phase 1.
  int p0_writes;
  int p0_reads;
  int p1_answers;
  int p1_ticks;
  int done_pulses;
  bit tick_started;
  bit tick_stopped;
  mem_test_pkg::mem_addr_t wr_addr_q [$];
  mem_test_pkg::mem_data_t wr_data_q [$];
  mem_test_pkg::mem_addr_t rd_addr_q [$];

  mem_test_top #(
    .timeout_ticks(300)
  ) DUT (
    .clock(clock),
    .reset_n(reset_n),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_we(mem_we),
    .mem_re(mem_re),
    .mem_rdata(mem_rdata),
    .mem_rvalid(mem_rvalid),
    .mem_ready(mem_ready),
    .done(done),
    .phase0_start(phase0_start),
    .phase1_start(phase1_start),
    .sw(sw),
    .led(led),
    .hex0(hex0),
    .hex1(hex1),
    .hex2(hex2),
    .hex3(hex3)
  );

  mem_model model (
    .clock(clock),
    .reset_n(reset_n),
    .corrupt(corrupt),
    .stuck_ready(stuck_ready),
    .silent(silent),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_we(mem_we),
    .mem_re(mem_re),
    .mem_rdata(mem_rdata),
    .mem_rvalid(mem_rvalid),
    .mem_ready(mem_ready)
  );

  initial begin
    forever #2 clock = ~clock;
  end

  task automatic check_equal(input logic [31:0] got, input logic [31:0] want,
                             input string what);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("Fail %0t: %s is %0h, expected %0h", $time, what, got, want);
    end
  endtask

  // Active-low segments built from the lit segment letters of each digit.
  function automatic mem_test_pkg::segments_t segments_for(input logic [3:0] digit);
    string lit;
    mem_test_pkg::segments_t segs;
    case (digit)
      4'h0: lit = "abcdef";
      4'h1: lit = "bc";
      4'h2: lit = "abdeg";
      4'h3: lit = "abcdg";
      4'h4: lit = "bcfg";
      4'h5: lit = "acdfg";
      4'h6: lit = "acdefg";
      4'h7: lit = "abc";
      4'h8: lit = "abcdefg";
      4'h9: lit = "abcfg";
      4'ha: lit = "abcefg";
      4'hb: lit = "cdefg";
      4'hc: lit = "adef";
      4'hd: lit = "bcdeg";
      4'he: lit = "adefg";
      default: lit = "aefg";
    endcase
    segs = '1;
    for (int i = 0; i < lit.len(); i++) begin
      segs[lit.getc(i) - "a"] = 1'b0;
    end
    return segs;
  endfunction

  function automatic logic [27:0] display_for(input logic [15:0] value);
    return {segments_for(value[15:12]), segments_for(value[11:8]),
            segments_for(value[7:4]), segments_for(value[3:0])};
  endfunction

  // Observes the memory bus at the rising edge, as the DUT sees it.
  always @(posedge clock) begin
    if (!reset_n) begin
      phase = 0;
      p0_writes = 0;
      p0_reads = 0;
      p1_answers = 0;
      p1_ticks = 0;
      done_pulses = 0;
      tick_started = 1'b0;
      tick_stopped = 1'b0;
      wr_addr_q.delete();
      wr_data_q.delete();
      rd_addr_q.delete();
    end else begin
      if (phase == 0) begin
        check_equal(mem_we || mem_re, 1'b0, "strobe before phase0_start");
      end
      if (phase0_start) begin
        check_equal(phase, 0, "phase at phase0_start");
        phase = 1;
      end
      if (phase == 1 && mem_we && mem_ready) begin
        p0_writes++;
        check_equal(p0_reads, 0, "phase-0 reads before the write");
        check_equal(mem_addr, 18341, "phase-0 write address");
        check_equal(mem_wdata, 16'hbeef, "phase-0 write data");
      end
      if (phase == 1 && mem_re && mem_ready) begin
        p0_reads++;
        check_equal(p0_writes, 1, "phase-0 writes before the read");
        check_equal(mem_addr, 18341, "phase-0 read address");
      end
      if (phase == 2) begin
        if (mem_we && mem_ready) begin
          tick_started = 1'b1;
          wr_addr_q.push_back(mem_addr);
          wr_data_q.push_back(mem_wdata);
        end
        if (mem_re && mem_ready) begin
          rd_addr_q.push_back(mem_addr);
        end
        if (tick_started && !tick_stopped) begin
          p1_ticks++; // From the first write through the last answer.
        end
        if (mem_rvalid) begin
          p1_answers++;
          if (p1_answers == 10) begin
            tick_stopped = 1'b1;
          end
        end
      end
      if (phase1_start) begin
        check_equal(phase, 1, "phase at phase1_start");
        phase = 2;
      end
      if (done) begin
        done_pulses++;
      end
    end
  end

  task automatic apply_reset(input logic corrupt_mode, input logic stuck_mode,
                             input logic silent_mode);
    @(negedge clock);
    reset_n = 1'b0;
    sw = '0;
    corrupt = corrupt_mode;
    stuck_ready = stuck_mode;
    silent = silent_mode;
    repeat (8) @(negedge clock);
    reset_n = 1'b1;
  endtask

  task automatic wait_for_done(input int limit);
    int cycles;
    cycles = 0;
    while (done_pulses == 0 && cycles < limit) begin
      @(negedge clock);
      cycles++;
    end
    if (done_pulses == 0) begin
      errors++;
      $display("No done pulse came within %0d cycles", limit);
    end
  endtask

  task automatic wait_for_display(input logic [15:0] value, input int limit);
    int cycles;
    cycles = 0;
    while ({hex3, hex2, hex1, hex0} !== display_for(value) && cycles < limit) begin
      @(negedge clock);
      cycles++;
    end
    if ({hex3, hex2, hex1, hex0} !== display_for(value)) begin
      errors++;
      $display("The display did not show %h within %0d cycles", value, limit);
    end
  endtask

  task automatic show_on_switches(input logic [9:0] setting, input logic [15:0] value,
                                  input string what);
    @(negedge clock);
    sw = setting;
    @(negedge clock);
    check_equal({hex3, hex2, hex1, hex0}, display_for(value), what);
  endtask

  task automatic check_phase1_traffic();
    int addr;
    addr = 18341;
    check_equal(wr_addr_q.size(), 10, "phase-1 write count");
    check_equal(rd_addr_q.size(), 10, "phase-1 read count");
    for (int i = 0; i < wr_addr_q.size() && i < rd_addr_q.size(); i++) begin
      if (i < 5) begin
        check_equal(wr_addr_q[i], addr, $sformatf("phase-1 write address %0d", i));
      end
      if (i == 9) begin
        check_equal(wr_addr_q[i], 0, "phase-1 write address 9");
      end
      check_equal(wr_data_q[i], i * 32'h1111, $sformatf("phase-1 write data %0d", i));
      check_equal(rd_addr_q[i], wr_addr_q[i], $sformatf("phase-1 read address %0d", i));
      addr = (addr % 10000) * 10 + addr / 10000; // Rotate the decimal digits.
    end
  endtask

  initial begin
    void'($urandom(35));

    apply_reset(1'b0, 1'b0, 1'b0);
    wait_for_done(400);
    repeat (5) @(negedge clock);
    check_equal(done_pulses, 1, "done pulses in normal mode");
    check_equal(p0_writes, 1, "phase-0 writes");
    check_equal(p0_reads, 1, "phase-0 reads");
    check_phase1_traffic();
    check_equal(led, 2'b11, "pass LEDs in normal mode");
    show_on_switches(10'b10_0000_0001, 16'h000a, "phase-1 correct count");
    show_on_switches(10'b10_0000_0000, 16'h0001, "phase-0 correct count");
    show_on_switches(10'b01_0000_0001, 16'h0000, "phase-1 ticks high half");
    show_on_switches(10'b00_0000_0001, p1_ticks[15:0], "phase-1 ticks low half");

    apply_reset(1'b1, 1'b0, 1'b0);
    wait_for_done(400);
    check_equal(led, 2'b01, "pass LEDs with a corrupt word");
    show_on_switches(10'b10_0000_0001, 16'h0009, "phase-1 correct count, corrupt");

    apply_reset(1'b0, 1'b1, 1'b0);
    wait_for_display(16'hdead, 50);
    check_equal(done_pulses, 0, "done pulses with ready stuck high");
    check_equal(led, 2'b00, "pass LEDs after a protocol error");

    apply_reset(1'b0, 1'b0, 1'b1);
    wait_for_display(16'h0bad, 300 + 50);
    repeat (20) @(negedge clock);
    check_equal({hex3, hex2, hex1, hex0}, display_for(16'h0bad), "display after timeout");
    check_equal(done_pulses, 0, "done pulses with silent memory");

    $display("Checks: %0d, errors: %0d, checker failures: %0d",
             checks, errors, DUT.checks.failures);
    if (errors == 0 && DUT.checks.failures == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule : mem_test_tb

`default_nettype wire

/* mem_test_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_test_checker (
  input wire logic clock,
  input wire logic reset_n,
  input wire logic mem_we,
  input wire logic mem_re,
  input wire logic mem_ready,
  input wire logic done,
  input wire logic phase0_start,
  input wire logic phase1_start,
  input wire mem_test_pkg::segments_t hex0,
  input wire mem_test_pkg::segments_t hex1,
  input wire mem_test_pkg::segments_t hex2,
  input wire mem_test_pkg::segments_t hex3
);

  int failures = 0;

  one_strobe: assert property (@(posedge clock) disable iff (!reset_n)
    !(mem_we && mem_re))
    else begin
      failures++;
      $error("mem_we and mem_re are high together");
    end

  strobe_needs_ready: assert property (@(posedge clock) disable iff (!reset_n)
    (mem_we || mem_re) |-> mem_ready)
    else begin
      failures++;
      $error("Strobe while mem_ready is low");
    end

  done_one_cycle: assert property (@(posedge clock) disable iff (!reset_n)
    done |=> !done)
    else begin
      failures++;
      $error("done lasts more than one cycle");
    end

  starts_one_cycle: assert property (@(posedge clock) disable iff (!reset_n)
    (phase0_start || phase1_start) |=> !(phase0_start || phase1_start))
    else begin
      failures++;
      $error("A start pulse lasts more than one cycle");
    end

  // A zero digit lights every segment except g.
  idle_after_reset: assert property (@(posedge clock)
    $rose(reset_n) |-> !(mem_we || mem_re || done || phase0_start || phase1_start)
      && {hex3, hex2, hex1, hex0} == {4{7'b1000000}})
    else begin
      failures++;
      $error("Outputs are not idle after reset");
    end

endmodule : mem_test_checker

bind mem_test_top mem_test_checker checks (
  .clock(clock),
  .reset_n(reset_n),
  .mem_we(mem_we),
  .mem_re(mem_re),
  .mem_ready(mem_ready),
  .done(done),
  .phase0_start(phase0_start),
  .phase1_start(phase1_start),
  .hex0(hex0),
  .hex1(hex1),
  .hex2(hex2),
  .hex3(hex3)
);

`default_nettype wire

/* mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_model (
  input wire logic clock,
  input wire logic reset_n,
  input wire logic corrupt,
  input wire logic stuck_ready,
  input wire logic silent,
  input wire mem_test_pkg::mem_addr_t mem_addr,
  input wire mem_test_pkg::mem_data_t mem_wdata,
  input wire logic mem_we,
  input wire logic mem_re,
  output mem_test_pkg::mem_data_t mem_rdata,
  output logic mem_rvalid,
  output logic mem_ready
);

  mem_test_pkg::mem_data_t memory [mem_test_pkg::mem_addr_t];
  mem_test_pkg::mem_data_t word;
  mem_test_pkg::mem_data_t read_word = '0;
  mem_test_pkg::mem_data_t rdata_q = '0;
  logic read_taken = 1'b0;
  logic running = 1'b0;
  logic busy = 1'b0;
  logic rvalid_q = 1'b0;
  logic ready_q = 1'b0;
  int delay = 0;

  assign mem_rdata = rdata_q;
  assign mem_rvalid = rvalid_q;
  assign mem_ready = ready_q;

  // Requests are taken at the rising edge, where the DUT sees them.
  always @(posedge clock) begin
    running <= reset_n;
    read_taken <= 1'b0;
    if (!reset_n) begin
      memory.delete();
    end else begin
      if (mem_we && mem_ready) begin
        memory[mem_addr] = mem_wdata;
      end
      if (mem_re && mem_ready) begin
        word = memory.exists(mem_addr) ? memory[mem_addr] : '0;
        if (corrupt && word == 16'h4444) begin
          word[0] = ~word[0]; // Table entry 4.
        end
        read_word <= word;
        read_taken <= 1'b1;
      end
    end
  end

  always @(negedge clock) begin
    rvalid_q = 1'b0;
    rdata_q = '0;
    if (!running) begin
      busy = 1'b0;
      delay = 0;
    end else if (read_taken) begin
      busy = 1'b1;
      delay = $urandom_range(4, 1);
    end else if (busy && !silent && !stuck_ready) begin
      delay--;
      if (delay == 0) begin
        busy = 1'b0;
        rvalid_q = 1'b1;
        rdata_q = read_word;
      end
    end
    ready_q = running && (stuck_ready || !busy);
  end

endmodule : mem_model

`default_nettype wire

/* mem_test_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_test_top #(
  parameter mem_test_pkg::tick_t timeout_ticks = '1
) (
  input wire logic clock,
  input wire logic reset_n,

  output mem_test_pkg::mem_addr_t mem_addr,
  output mem_test_pkg::mem_data_t mem_wdata,
  output logic mem_we,
  output logic mem_re,
  input wire mem_test_pkg::mem_data_t mem_rdata,
  input wire logic mem_rvalid,
  input wire logic mem_ready,

  output logic done,
  output logic phase0_start,
  output logic phase1_start,

  input wire logic [9:0] sw,
  output logic [1:0] led,
  output mem_test_pkg::segments_t hex0,
  output mem_test_pkg::segments_t hex1,
  output mem_test_pkg::segments_t hex2,
  output mem_test_pkg::segments_t hex3
);

  mem_test_pkg::count_t issued;
  mem_test_pkg::count_t completed;
  mem_test_pkg::tick_t ticks [mem_test_pkg::num_phases];
  mem_test_pkg::correct_t corrects [mem_test_pkg::num_phases];

  logic inc_issued;
  logic clr_issued;
  logic inc_completed;
  logic clr_completed;
  logic [mem_test_pkg::num_phases-1:0] tick_inc;
  logic clr_ticks;
  logic [mem_test_pkg::num_phases-1:0] correct_inc;
  logic clr_correct;

  mem_test_pkg::count_t pattern_index;
  mem_test_pkg::mem_addr_t pattern_addr;
  mem_test_pkg::mem_data_t pattern_data;

  mem_test_pkg::test_state_t state;

  phase_sequencer #(
    .timeout_ticks(timeout_ticks)
  ) u_sequencer (
    .clock(clock),
    .reset_n(reset_n),
    .mem_rdata(mem_rdata),
    .mem_rvalid(mem_rvalid),
    .mem_ready(mem_ready),
    .issued(issued),
    .completed(completed),
    .ticks(ticks),
    .pattern_addr(pattern_addr),
    .pattern_data(pattern_data),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_we(mem_we),
    .mem_re(mem_re),
    .done(done),
    .phase0_start(phase0_start),
    .phase1_start(phase1_start),
    .pattern_index(pattern_index),
    .state(state),
    .inc_issued(inc_issued),
    .clr_issued(clr_issued),
    .inc_completed(inc_completed),
    .clr_completed(clr_completed),
    .tick_inc(tick_inc),
    .clr_ticks(clr_ticks),
    .correct_inc(correct_inc),
    .clr_correct(clr_correct)
  );

  test_counters u_counters (
    .clock(clock),
    .reset_n(reset_n),
    .inc_issued(inc_issued),
    .clr_issued(clr_issued),
    .inc_completed(inc_completed),
    .clr_completed(clr_completed),
    .tick_inc(tick_inc),
    .clr_ticks(clr_ticks),
    .correct_inc(correct_inc),
    .clr_correct(clr_correct),
    .issued(issued),
    .completed(completed),
    .ticks(ticks),
    .corrects(corrects)
  );

  pattern_table u_table (
    .pattern_index(pattern_index),
    .pattern_addr(pattern_addr),
    .pattern_data(pattern_data)
  );

  result_display u_display (
    .state(state),
    .ticks(ticks),
    .corrects(corrects),
    .sw(sw),
    .led(led),
    .hex0(hex0),
    .hex1(hex1),
    .hex2(hex2),
    .hex3(hex3)
  );

endmodule : mem_test_top

`default_nettype wire

/* phase_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module phase_sequencer #(
  parameter mem_test_pkg::tick_t timeout_ticks = '1
) (
  input wire logic clock,
  input wire logic reset_n,

  input wire mem_test_pkg::mem_data_t mem_rdata,
  input wire logic mem_rvalid,
  input wire logic mem_ready,

  input wire mem_test_pkg::count_t issued,
  input wire mem_test_pkg::count_t completed,
  input wire mem_test_pkg::tick_t ticks [mem_test_pkg::num_phases],

  input wire mem_test_pkg::mem_addr_t pattern_addr,
  input wire mem_test_pkg::mem_data_t pattern_data,

  output mem_test_pkg::mem_addr_t mem_addr,
  output mem_test_pkg::mem_data_t mem_wdata,
  output logic mem_we,
  output logic mem_re,

  output logic done,
  output logic phase0_start,
  output logic phase1_start,

  output mem_test_pkg::count_t pattern_index,
  output mem_test_pkg::test_state_t state,

  output logic inc_issued,
  output logic clr_issued,
  output logic inc_completed,
  output logic clr_completed,
  output logic [mem_test_pkg::num_phases-1:0] tick_inc,
  output logic clr_ticks,
  output logic [mem_test_pkg::num_phases-1:0] correct_inc,
  output logic clr_correct
);

  mem_test_pkg::test_state_t next_state;
  logic armed; // Holds off the start pulse for the first cycle out of reset.
  logic clear_all;
  logic last_arrives;

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      state <= mem_test_pkg::idle;
      armed <= 1'b0;
    end else begin
      state <= next_state;
      armed <= 1'b1;
    end
  end

  // A returning word owns the table lookup, so reads stall for that cycle.
  assign pattern_index = (state == mem_test_pkg::phase1_rd && mem_rvalid) ? completed : issued;

  assign last_arrives = mem_rvalid && completed == mem_test_pkg::phase1_words - 1'b1;

  always_comb begin
    mem_addr = '0;
    mem_wdata = '0;
    mem_we = 1'b0;
    mem_re = 1'b0;
    done = 1'b0;
    phase0_start = 1'b0;
    phase1_start = 1'b0;
    inc_issued = 1'b0;
    clr_issued = 1'b0;
    inc_completed = 1'b0;
    clr_completed = 1'b0;
    tick_inc = '0;
    clr_ticks = 1'b0;
    correct_inc = '0;
    clr_correct = 1'b0;
    clear_all = 1'b0;
    next_state = state;

    case (state)
      mem_test_pkg::idle: begin
        if (armed) begin
          phase0_start = 1'b1;
          next_state = mem_test_pkg::phase0_wr;
        end
      end

      mem_test_pkg::phase0_wr: begin
        if (mem_ready) begin
          mem_addr = mem_test_pkg::phase0_addr;
          mem_wdata = mem_test_pkg::phase0_data;
          mem_we = 1'b1;
          tick_inc[0] = 1'b1;
          next_state = mem_test_pkg::phase0_rd;
        end
      end

      mem_test_pkg::phase0_rd: begin
        if (issued != '0 && mem_ready && !mem_rvalid) begin
          clear_all = 1'b1; // Ready again with the only read unanswered.
          next_state = mem_test_pkg::error;
        end else if (ticks[0] >= timeout_ticks) begin
          clear_all = 1'b1;
          next_state = mem_test_pkg::timeout;
        end else begin
          tick_inc[0] = 1'b1;
          if (mem_ready && issued == '0) begin
            mem_addr = mem_test_pkg::phase0_addr;
            mem_re = 1'b1;
            inc_issued = 1'b1;
          end
          if (mem_rvalid) begin
            correct_inc[0] = mem_rdata == mem_test_pkg::phase0_data;
            phase1_start = 1'b1;
            clr_issued = 1'b1;
            next_state = mem_test_pkg::phase1_wr;
          end
        end
      end

      mem_test_pkg::phase1_wr: begin
        if (mem_ready) begin
          mem_addr = pattern_addr;
          mem_wdata = pattern_data;
          mem_we = 1'b1;
          tick_inc[1] = 1'b1;
          if (issued == mem_test_pkg::phase1_words - 1'b1) begin
            clr_issued = 1'b1;
            next_state = mem_test_pkg::phase1_rd;
          end else begin
            inc_issued = 1'b1;
          end
        end else if (ticks[1] != '0) begin
          tick_inc[1] = 1'b1; // Stalled after the first write still counts.
        end
      end

      mem_test_pkg::phase1_rd: begin
        if (issued == mem_test_pkg::phase1_words && mem_ready && !last_arrives) begin
          clear_all = 1'b1;
          next_state = mem_test_pkg::error;
        end else if (ticks[1] >= timeout_ticks) begin
          clear_all = 1'b1;
          next_state = mem_test_pkg::timeout;
        end else begin
          tick_inc[1] = 1'b1;
          if (mem_ready && !mem_rvalid && issued < mem_test_pkg::phase1_words) begin
            mem_addr = pattern_addr;
            mem_re = 1'b1;
            inc_issued = 1'b1;
          end
          if (mem_rvalid) begin
            inc_completed = 1'b1;
            correct_inc[1] = mem_rdata == pattern_data;
            if (last_arrives) begin
              done = 1'b1;
              clr_issued = 1'b1;
              clr_completed = 1'b1;
              next_state = mem_test_pkg::report;
            end
          end
        end
      end

      mem_test_pkg::report: begin
      end

      mem_test_pkg::error,
      mem_test_pkg::timeout: begin
        clear_all = 1'b1;
      end

      default: begin
        next_state = mem_test_pkg::idle;
      end
    endcase

    if (clear_all) begin
      clr_issued = 1'b1;
      clr_completed = 1'b1;
      clr_ticks = 1'b1;
      clr_correct = 1'b1;
    end
  end

endmodule : phase_sequencer

`default_nettype wire

/* result_display.sv */
`timescale 1ns/1ps
`default_nettype none

module result_display (
  input wire mem_test_pkg::test_state_t state,
  input wire mem_test_pkg::tick_t ticks [mem_test_pkg::num_phases],
  input wire mem_test_pkg::correct_t corrects [mem_test_pkg::num_phases],
  input wire logic [9:0] sw,
  output logic [1:0] led,
  output mem_test_pkg::segments_t hex0,
  output mem_test_pkg::segments_t hex1,
  output mem_test_pkg::segments_t hex2,
  output mem_test_pkg::segments_t hex3
);

  mem_test_pkg::hex_t shown;

  always_comb begin
    case (state)
      mem_test_pkg::report: begin
        if (sw[9]) begin
          shown = corrects[sw[0]];
        end else if (sw[8]) begin
          shown = ticks[sw[0]][31:16];
        end else begin
          shown = ticks[sw[0]][15:0];
        end
      end
      mem_test_pkg::error: shown = mem_test_pkg::error_code;
      mem_test_pkg::timeout: shown = mem_test_pkg::timeout_code;
      default: shown = '0;
    endcase
  end

  assign led[0] = corrects[0] == mem_test_pkg::phase0_pass_count;
  assign led[1] = corrects[1] == mem_test_pkg::correct_t'(mem_test_pkg::phase1_words);

  seg7_decoder u_digit0 (
    .digit(shown[3:0]),
    .segments(hex0)
  );

  seg7_decoder u_digit1 (
    .digit(shown[7:4]),
    .segments(hex1)
  );

  seg7_decoder u_digit2 (
    .digit(shown[11:8]),
    .segments(hex2)
  );

  seg7_decoder u_digit3 (
    .digit(shown[15:12]),
    .segments(hex3)
  );

endmodule : result_display

`default_nettype wire

/* test_counters.sv */
`timescale 1ns/1ps
`default_nettype none

module test_counters (
  input wire logic clock,
  input wire logic reset_n,

  input wire logic inc_issued,
  input wire logic clr_issued,
  input wire logic inc_completed,
  input wire logic clr_completed,
  input wire logic [mem_test_pkg::num_phases-1:0] tick_inc,
  input wire logic clr_ticks,
  input wire logic [mem_test_pkg::num_phases-1:0] correct_inc,
  input wire logic clr_correct,

  output mem_test_pkg::count_t issued,
  output mem_test_pkg::count_t completed,
  output mem_test_pkg::tick_t ticks [mem_test_pkg::num_phases],
  output mem_test_pkg::correct_t corrects [mem_test_pkg::num_phases]
);

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      issued <= '0;
    end else if (clr_issued) begin
      issued <= '0;
    end else if (inc_issued) begin
      issued <= issued + 1'b1;
    end
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      completed <= '0;
    end else if (clr_completed) begin
      completed <= '0;
    end else if (inc_completed) begin
      completed <= completed + 1'b1;
    end
  end

  // Clears act on every phase at once; increments are per phase.
  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      for (int p = 0; p < mem_test_pkg::num_phases; p++) begin
        ticks[p] <= '0;
        corrects[p] <= '0;
      end
    end else begin
      for (int p = 0; p < mem_test_pkg::num_phases; p++) begin
        if (clr_ticks) begin
          ticks[p] <= '0;
        end else if (tick_inc[p]) begin
          ticks[p] <= ticks[p] + 1'b1;
        end
        if (clr_correct) begin
          corrects[p] <= '0;
        end else if (correct_inc[p]) begin
          corrects[p] <= corrects[p] + 1'b1;
        end
      end
    end
  end

endmodule : test_counters

`default_nettype wire

/* pattern_table.sv */
`timescale 1ns/1ps
`default_nettype none

module pattern_table (
  input wire mem_test_pkg::count_t pattern_index,
  output mem_test_pkg::mem_addr_t pattern_addr,
  output mem_test_pkg::mem_data_t pattern_data
);

  always_comb begin
    pattern_addr = '0;
    pattern_data = '0;

    case (pattern_index)
      10'd0: pattern_addr = 22'd18341;
      10'd1: pattern_addr = 22'd83411;
      10'd2: pattern_addr = 22'd34118;
      10'd3: pattern_addr = 22'd41183;
      10'd4: pattern_addr = 22'd11834;
      10'd5: pattern_addr = 22'b10_0000_0101_0101_0101_0101;
      10'd6: pattern_addr = 22'b01_0000_1010_1010_1010_1010;
      10'd7: pattern_addr = 22'b00_1000_0000_0000_1111_1111;
      10'd8: pattern_addr = 22'h3f_ffff;
      10'd9: pattern_addr = 22'h00_0000;
      default: pattern_addr = '0;
    endcase

    if (pattern_index < mem_test_pkg::phase1_words) begin
      pattern_data = {4{pattern_index[3:0]}}; // Index in every nibble.
    end
  end

endmodule : pattern_table

`default_nettype wire

/* seg7_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module seg7_decoder (
  input wire logic [3:0] digit,
  output mem_test_pkg::segments_t segments
);

  // Segment order is g down to a and a lit segment is low.
  always_comb begin
    case (digit)
      4'h0: segments = 7'b1000000;
      4'h1: segments = 7'b1111001;
      4'h2: segments = 7'b0100100;
      4'h3: segments = 7'b0110000;
      4'h4: segments = 7'b0011001;
      4'h5: segments = 7'b0010010;
      4'h6: segments = 7'b0000010;
      4'h7: segments = 7'b1111000;
      4'h8: segments = 7'b0000000;
      4'h9: segments = 7'b0011000;
      4'ha: segments = 7'b0001000;
      4'hb: segments = 7'b0000011;
      4'hc: segments = 7'b1000110;
      4'hd: segments = 7'b0100001;
      4'he: segments = 7'b0000110;
      default: segments = 7'b0001110; // Digit f.
    endcase
  end

endmodule : seg7_decoder

`default_nettype wire

/* mem_test_pkg.sv */
`default_nettype none

package mem_test_pkg;

  typedef logic [21:0] mem_addr_t;
  typedef logic [15:0] mem_data_t;
  typedef logic [9:0] count_t;
  typedef logic [31:0] tick_t;
  typedef logic [15:0] correct_t;
  typedef logic [15:0] hex_t;
  typedef logic [6:0] segments_t;

  typedef enum logic [2:0] {
    idle,
    phase0_wr,
    phase0_rd,
    phase1_wr,
    phase1_rd,
    report,
    error,
    timeout
  } test_state_t;

  localparam int num_phases = 2;

  localparam mem_addr_t phase0_addr = 22'd18341;
  localparam mem_data_t phase0_data = 16'hbeef;

  localparam count_t phase1_words = 10; // Entries in the phase-1 table.

  localparam hex_t error_code = 16'hdead;
  localparam hex_t timeout_code = 16'h0bad;

  localparam correct_t phase0_pass_count = 1;

endpackage : mem_test_pkg

`default_nettype wire
